// File: control_decode.sv
module control_decode (
    input  decode_pkg::inst_t    instr,
    input  decode_pkg::word_t    imm,
    input  decode_pkg::word_t    op_a,
    input  decode_pkg::word_t    op_b,
    output decode_pkg::alu_op_e  alu_op,
    output decode_pkg::mem_op_e  mem_op,
    output decode_pkg::wb_type_e wb_type,
    output logic                 wb_en,
    output logic                 wb_from_alu,
    output logic                 illegal,
    output decode_pkg::word_t    alu_a,
    output decode_pkg::word_t    alu_b,
    output decode_pkg::word_t    store_data
);

    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;  // funct7 bit 30 that selects SUB and SRA

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    always_comb begin
        // Inactive controls unless an opcode below claims the slot
        alu_op      = ALU_NOP;
        mem_op      = MEM_NOP;
        wb_type     = WB_WORD;
        wb_en       = 1'b0;
        wb_from_alu = 1'b0;
        illegal     = 1'b0;
        alu_a       = '0;
        alu_b       = '0;
        store_data  = '0;

        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                wb_en       = 1'b1;
                wb_from_alu = 1'b1;      // Result comes straight from the ALU
                alu_a       = op_a;      // Forwarded rs1
                alu_b       = (opcode == OPC_OP) ? op_b : imm;
                case (funct3)
                    F3_ADD_SUB: begin
                        // Bit 30 belongs to the immediate for ADDI
                        alu_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
                    end
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = alt ? ALU_SRA : ALU_SRL;  // Same split for SRLI/SRAI
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                endcase
            end

            OPC_LOAD: begin
                alu_op = ALU_ADD;  // Address = rs1 + imm
                mem_op = MEM_LOAD;
                wb_en  = 1'b1;     // wb_from_alu stays low for data from memory
                alu_a  = op_a;
                alu_b  = imm;
                case (funct3)
                    F3_LB:   wb_type = WB_BYTE_S;
                    F3_LH:   wb_type = WB_HALF_S;
                    F3_LW:   wb_type = WB_WORD;
                    F3_LBU:  wb_type = WB_BYTE_U;
                    F3_LHU:  wb_type = WB_HALF_U;
                    default: illegal = 1'b1;
                endcase
            end

            OPC_STORE: begin
                alu_op     = ALU_ADD;
                mem_op     = MEM_STORE;
                alu_a      = op_a;
                alu_b      = imm;   // S immediate from imm_gen
                store_data = op_b;  // Forwarded rs2
                case (funct3)
                    F3_SB:   wb_type = WB_BYTE_S;  // Width of the write
                    F3_SH:   wb_type = WB_HALF_S;
                    F3_SW:   wb_type = WB_WORD;
                    default: illegal = 1'b1;
                endcase
            end

            OPC_BUBBLE: begin
                // Only the all-zero word is a bubble
                illegal = (instr[31:7] != '0);
            end

            default: begin
                // JAL, JALR, branches, LUI, AUIPC, FENCE, SYSTEM and unknown
                illegal = 1'b1;
            end
        endcase

        if (illegal) begin  // Illegal slot behaves as a bubble with the flag set
            alu_op      = ALU_NOP;
            mem_op      = MEM_NOP;
            wb_type     = WB_WORD;
            wb_en       = 1'b0;
            wb_from_alu = 1'b0;
            alu_a       = '0;
            alu_b       = '0;
            store_data  = '0;
        end
    end

endmodule

// File: decode_pkg.sv
package decode_pkg;

    // Data path and field widths
    localparam int XLEN      = 32;  // Integer register width
    localparam int FWD_DEPTH = 3;   // Younger stages that can forward a result

    typedef logic [XLEN-1:0] word_t;      // One data word
    typedef logic [31:0]     inst_t;      // One instruction
    typedef logic [4:0]      reg_addr_t;  // Register file offset

    localparam reg_addr_t REG_ZERO = 5'd0;  // x0, reads as zero and is never forwarded

    // Major opcodes still decoded, everything else is illegal
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;  // LB, LH, LW, LBU, LHU
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;  // SB, SH, SW
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;  // ADDI .. SRAI
    localparam logic [6:0] OPC_OP     = 7'b011_0011;  // ADD .. AND
    localparam logic [6:0] OPC_BUBBLE = 7'b000_0000;  // Inserted bubble, whole word zero

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;  // Split by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // funct3 for stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // ALU operation passed to execute
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,  // Idle, also the reset value
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLL  = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_AND  = 4'd10
    } alu_op_e;

    // Memory stage access
    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Width of load result or store data
    typedef enum logic [2:0] {
        WB_WORD   = 3'd0,  // Full word, default when unused
        WB_BYTE_S = 3'd1,  // Byte, sign extended
        WB_HALF_S = 3'd2,  // Half word, sign extended
        WB_BYTE_U = 3'd3,  // Byte, zero extended
        WB_HALF_U = 3'd4   // Half word, zero extended
    } wb_type_e;

endpackage

// File: decode_stage.sv
module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  decode_pkg::inst_t     instr,
    output decode_pkg::reg_addr_t rs1_addr,       // To register file
    output decode_pkg::reg_addr_t rs2_addr,
    input  decode_pkg::word_t     rs1_data,       // Same-cycle read data
    input  decode_pkg::word_t     rs2_data,
    input  decode_pkg::word_t     ex_result,      // Forwarding sources
    input  decode_pkg::word_t     mem_result,
    input  decode_pkg::word_t     wb_result,
    output decode_pkg::reg_addr_t ex_rd,
    output decode_pkg::alu_op_e   ex_alu_op,
    output decode_pkg::mem_op_e   ex_mem_op,
    output decode_pkg::wb_type_e  ex_wb_type,
    output logic                  ex_wb_en,
    output logic                  ex_wb_from_alu,
    output logic                  ex_illegal,
    output decode_pkg::word_t     ex_alu_a,
    output decode_pkg::word_t     ex_alu_b,
    output decode_pkg::word_t     ex_store_data
);

    import decode_pkg::*;

    reg_addr_t rd;
    word_t     imm;
    word_t     op_a;         // Forwarded rs1 value
    word_t     op_b;         // Forwarded rs2 value
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    wb_type_e  wb_type;
    logic      wb_en;
    logic      wb_from_alu;
    logic      illegal;
    word_t     alu_a;
    word_t     alu_b;
    word_t     store_data;

    // Field extraction, register offsets go straight out to the register file
    imm_gen i_imm_gen (
        .instr (instr),
        .rd    (rd),
        .rs1   (rs1_addr),
        .rs2   (rs2_addr),
        .imm   (imm)
    );

    operand_forward i_operand_forward (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1        (rs1_addr),
        .rs2        (rs2_addr),
        .rd         (rd),
        .wb_en      (wb_en),
        .illegal    (illegal),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .op_a       (op_a),
        .op_b       (op_b)
    );

    control_decode i_control_decode (
        .instr       (instr),
        .imm         (imm),
        .op_a        (op_a),
        .op_b        (op_b),
        .alu_op      (alu_op),
        .mem_op      (mem_op),
        .wb_type     (wb_type),
        .wb_en       (wb_en),
        .wb_from_alu (wb_from_alu),
        .illegal     (illegal),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .store_data  (store_data)
    );

    // Single register stage, fixes the one-clock latency
    id_ex_reg i_id_ex_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd             (rd),
        .alu_op         (alu_op),
        .mem_op         (mem_op),
        .wb_type        (wb_type),
        .wb_en          (wb_en),
        .wb_from_alu    (wb_from_alu),
        .illegal        (illegal),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .store_data     (store_data),
        .ex_rd          (ex_rd),
        .ex_alu_op      (ex_alu_op),
        .ex_mem_op      (ex_mem_op),
        .ex_wb_type     (ex_wb_type),
        .ex_wb_en       (ex_wb_en),
        .ex_wb_from_alu (ex_wb_from_alu),
        .ex_illegal     (ex_illegal),
        .ex_alu_a       (ex_alu_a),
        .ex_alu_b       (ex_alu_b),
        .ex_store_data  (ex_store_data)
    );

endmodule

// File: id_ex_reg.sv
module id_ex_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  decode_pkg::reg_addr_t rd,
    input  decode_pkg::alu_op_e   alu_op,
    input  decode_pkg::mem_op_e   mem_op,
    input  decode_pkg::wb_type_e  wb_type,
    input  logic                  wb_en,
    input  logic                  wb_from_alu,
    input  logic                  illegal,
    input  decode_pkg::word_t     alu_a,
    input  decode_pkg::word_t     alu_b,
    input  decode_pkg::word_t     store_data,
    output decode_pkg::reg_addr_t ex_rd,
    output decode_pkg::alu_op_e   ex_alu_op,
    output decode_pkg::mem_op_e   ex_mem_op,
    output decode_pkg::wb_type_e  ex_wb_type,
    output logic                  ex_wb_en,
    output logic                  ex_wb_from_alu,
    output logic                  ex_illegal,
    output decode_pkg::word_t     ex_alu_a,
    output decode_pkg::word_t     ex_alu_b,
    output decode_pkg::word_t     ex_store_data
);

    import decode_pkg::*;

    // Reset state is the idle pipeline, same as a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_rd          <= REG_ZERO;
            ex_alu_op      <= ALU_NOP;
            ex_mem_op      <= MEM_NOP;
            ex_wb_type     <= WB_WORD;
            ex_wb_en       <= 1'b0;
            ex_wb_from_alu <= 1'b0;
            ex_illegal     <= 1'b0;
            ex_alu_a       <= '0;
            ex_alu_b       <= '0;
            ex_store_data  <= '0;
        end else begin
            // No write-back means no destination downstream
            ex_rd          <= wb_en ? rd : REG_ZERO;
            ex_alu_op      <= alu_op;
            ex_mem_op      <= mem_op;
            ex_wb_type     <= wb_type;
            ex_wb_en       <= wb_en;
            ex_wb_from_alu <= wb_from_alu;
            ex_illegal     <= illegal;  // Travels with the slot for a later trap
            ex_alu_a       <= alu_a;
            ex_alu_b       <= alu_b;
            ex_store_data  <= store_data;
        end
    end

endmodule

// File: imm_gen.sv
module imm_gen (
    input  decode_pkg::inst_t     instr,
    output decode_pkg::reg_addr_t rd,
    output decode_pkg::reg_addr_t rs1,
    output decode_pkg::reg_addr_t rs2,
    output decode_pkg::word_t     imm
);

    import decode_pkg::*;

    logic [6:0] opcode;
    logic       reads_rs1;  // Format has a real rs1 field
    logic       reads_rs2;  // Only R and S formats
    logic       writes_rd;  // Stores have no rd, bits 11:7 are immediate
    word_t      imm_i;
    word_t      imm_s;

    assign opcode = instr[6:0];

    always_comb begin
        reads_rs1 = 1'b0;
        reads_rs2 = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            OPC_OP: begin  // R-type reads both sources
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_OP_IMM, OPC_LOAD: begin  // I-type
                reads_rs1 = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_STORE: begin  // S-type, base plus data register
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
            end
            default: begin
                // Bubble and dropped formats carry no register offsets
                reads_rs1 = 1'b0;
            end
        endcase
    end

    // Masked offsets keep the forwarding compare away from immediate bits
    assign rd  = writes_rd ? instr[11:7]  : REG_ZERO;
    assign rs1 = reads_rs1 ? instr[19:15] : REG_ZERO;
    assign rs2 = reads_rs2 ? instr[24:20] : REG_ZERO;

    // I-format, imm[11:0] = instr[31:20]
    assign imm_i = {{(XLEN - 12){instr[31]}}, instr[31:20]};

    // S-format, imm[11:5] = instr[31:25], imm[4:0] = instr[11:7]
    assign imm_s = {{(XLEN - 12){instr[31]}}, instr[31:25], instr[11:7]};

    assign imm = (opcode == OPC_STORE) ? imm_s : imm_i;  // Sign bit is always instr[31]

endmodule

// File: operand_forward.sv
module operand_forward (
    input  logic                  clk,
    input  logic                  rst_n,
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  decode_pkg::reg_addr_t rd,
    input  logic                  wb_en,
    input  logic                  illegal,
    input  decode_pkg::word_t     rs1_data,
    input  decode_pkg::word_t     rs2_data,
    input  decode_pkg::word_t     ex_result,
    input  decode_pkg::word_t     mem_result,
    input  decode_pkg::word_t     wb_result,
    output decode_pkg::word_t     op_a,
    output decode_pkg::word_t     op_b
);

    import decode_pkg::*;

    reg_addr_t rd_hist [FWD_DEPTH];     // Entry 0 is the instruction decoded last cycle
    word_t     stage_res [FWD_DEPTH];   // Results lined up with rd_hist
    reg_addr_t rd_written;              // What this instruction will write, or x0

    // Only legal instructions that write back enter the history
    assign rd_written = (wb_en && !illegal) ? rd : REG_ZERO;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FWD_DEPTH; i++) begin
                rd_hist[i] <= REG_ZERO;
            end
        end else begin
            rd_hist[0] <= rd_written;
            for (int i = 1; i < FWD_DEPTH; i++) begin
                rd_hist[i] <= rd_hist[i-1];  // Shifts every clock, no stall
            end
        end
    end

    assign stage_res[0] = ex_result;   // One cycle older
    assign stage_res[1] = mem_result;  // Two cycles older
    assign stage_res[2] = wb_result;   // Three cycles older

    // Operand A from rs1
    always_comb begin
        op_a = rs1_data;
        // Oldest first so the youngest match overwrites
        for (int i = FWD_DEPTH - 1; i >= 0; i--) begin
            if (rs1 != REG_ZERO && rs1 == rd_hist[i]) begin
                op_a = stage_res[i];
            end
        end
    end

    // Operand B from rs2, also the store data
    always_comb begin
        op_b = rs2_data;
        for (int i = FWD_DEPTH - 1; i >= 0; i--) begin
            if (rs2 != REG_ZERO && rs2 == rd_hist[i]) begin
                op_b = stage_res[i];
            end
        end
    end

endmodule

// File: project.f
decode_pkg.sv
imm_gen.sv
control_decode.sv
operand_forward.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
# The run passes only when the log holds the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_decode_stage -f project.f \
    > sim.log 2>&1 \
    && ./obj_dir/Vtb_decode_stage >> sim.log 2>&1
cat sim.log
grep -q 'All tests passed!' sim.log \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed, see sim.log"; exit 1; }

// File: tb_decode_stage.sv
module tb_decode_stage;

    import decode_pkg::*;

    localparam int RST_CYCLES  = 16;
    localparam int RAND_CYCLES = 400;
    localparam int TAIL_CYCLES = 4;  // Bubbles that let the last real slot reach a check

    logic       clk = 1'b0;
    logic       rst_n;
    inst_t      instr;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      ex_result;
    word_t      mem_result;
    word_t      wb_result;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  ex_rd;
    alu_op_e    ex_alu_op;
    mem_op_e    ex_mem_op;
    wb_type_e   ex_wb_type;
    logic       ex_wb_en;
    logic       ex_wb_from_alu;
    logic       ex_illegal;
    word_t      ex_alu_a;
    word_t      ex_alu_b;
    word_t      ex_store_data;

    word_t      regs [32];     // Register file model
    reg_addr_t  hist [3];      // Model of written rd with entry 0 the youngest
    logic [6:0] opc;
    logic [2:0] f3;
    reg_addr_t  src1;
    reg_addr_t  src2;
    word_t      imm_i;
    word_t      imm_s;
    reg_addr_t  nxt_rs1, nxt_rs2, nxt_rd;
    logic [3:0] nxt_alu, exp_alu_op;
    logic [1:0] nxt_mem, exp_mem_op;
    logic [2:0] nxt_wbt, exp_wb_type;
    logic       nxt_wb, nxt_from_alu, nxt_ill;
    logic       exp_wb_en, exp_wb_from_alu, exp_illegal;
    word_t      nxt_a, nxt_b, nxt_sd;
    word_t      exp_alu_a, exp_alu_b, exp_store_data;
    reg_addr_t  exp_rd;
    inst_t      dir_q [$];
    logic [6:0] dropped [7] = '{7'h6F, 7'h67, 7'h63, 7'h37, 7'h17, 7'h0F, 7'h73};
    integer     seed;
    int         val_errs = 0;
    int         addr_errs = 0;
    int         cycles = 0;
    int         cycle_limit;

    decode_stage i_decode_stage (.*);

    always #10 clk = ~clk;

    assign rs1_data = regs[rs1_addr];  // Same-cycle read
    assign rs2_data = regs[rs2_addr];

    function automatic inst_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] fn3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, fn3, rd, OPC_OP};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] fn3, input reg_addr_t rd,
                                     input logic [6:0] op);
        return {imm, rs1, fn3, rd, op};
    endfunction

    function automatic inst_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] fn3);
        return {imm[11:5], rs2, rs1, fn3, imm[4:0], OPC_STORE};  // Offset split around rs fields
    endfunction

    // Youngest written copy wins and x0 always reads the register file
    function automatic word_t fwd(input reg_addr_t src, input word_t rf);
        if (src == REG_ZERO) return rf;
        if (src == hist[0]) return ex_result;
        if (src == hist[1]) return mem_result;
        if (src == hist[2]) return wb_result;
        return rf;
    endfunction

    function automatic logic [3:0] alu_code(input logic [2:0] fn3, input logic alt);
        case (fn3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic inst_t random_instr();
        logic [31:0] r;
        logic [31:0] v;
        logic [2:0]  fn3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r   = $random(seed);
        v   = $random(seed);
        fn3 = r[14:12];
        f7  = ((fn3 == F3_ADD_SUB || fn3 == F3_SRL_SRA) && r[15]) ? 7'h20 : 7'h00;
        imm = v[11:0];
        if (fn3 == F3_SLL || fn3 == F3_SRL_SRA)
            imm[11:5] = f7;  // Shift amount form
        // Registers x0..x7 only so that sources hit recent writes often
        case (r[11:9])
            3'd0, 3'd1: return r_type(f7, {2'b00, r[8:6]}, {2'b00, r[5:3]}, fn3, {2'b00, r[2:0]});
            3'd2, 3'd3: return i_type(imm, {2'b00, r[5:3]}, fn3, {2'b00, r[2:0]}, OPC_OP_IMM);
            3'd4:       return i_type(v[11:0], {2'b00, r[5:3]}, fn3, {2'b00, r[2:0]}, OPC_LOAD);
            3'd5:       return s_type(v[11:0], {2'b00, r[8:6]}, {2'b00, r[5:3]}, fn3);
            3'd6:       return '0;
            default:    return v;  // Mostly dropped opcodes
        endcase
    endfunction

    // Reference decode of the word now at instr
    always_comb begin
        opc   = instr[6:0];
        f3    = instr[14:12];
        src1  = instr[19:15];
        src2  = instr[24:20];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        {nxt_rs1, nxt_rs2, nxt_rd} = '0;
        {nxt_alu, nxt_mem, nxt_wbt, nxt_wb, nxt_from_alu, nxt_ill} = '0;  // NOP, NOP, WORD
        {nxt_a, nxt_b, nxt_sd} = '0;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            nxt_rs1      = src1;
            nxt_rd       = instr[11:7];
            nxt_wb       = 1'b1;
            nxt_from_alu = 1'b1;
            nxt_a        = fwd(src1, regs[src1]);
            nxt_b        = imm_i;
            nxt_alu      = alu_code(f3, instr[30] && (opc == OPC_OP || f3 == F3_SRL_SRA));
            if (opc == OPC_OP) begin
                nxt_rs2 = src2;
                nxt_b   = fwd(src2, regs[src2]);
            end
        end else if (opc == OPC_LOAD || opc == OPC_STORE) begin
            nxt_rs1 = src1;
            nxt_alu = ALU_ADD;  // Base plus offset
            nxt_a   = fwd(src1, regs[src1]);
            if (opc == OPC_LOAD) begin
                nxt_rd  = instr[11:7];
                nxt_wb  = 1'b1;
                nxt_mem = MEM_LOAD;
                nxt_b   = imm_i;
                nxt_ill = (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7);
                nxt_wbt = (f3[1:0] == 2'd2) ? WB_WORD : (f3[0] ? (f3[2] ? WB_HALF_U : WB_HALF_S)
                                                                 : (f3[2] ? WB_BYTE_U : WB_BYTE_S));
            end else begin
                nxt_rs2 = src2;
                nxt_mem = MEM_STORE;
                nxt_b   = imm_s;
                nxt_sd  = fwd(src2, regs[src2]);
                nxt_ill = (f3 > 3'd2);
                nxt_wbt = (f3 == 3'd0) ? WB_BYTE_S : ((f3 == 3'd1) ? WB_HALF_S : WB_WORD);
            end
        end else begin
            nxt_ill = (instr != '0);  // Only the all-zero word is a bubble
        end
        if (nxt_ill) begin  // Addresses still go out while everything else idles
            {nxt_rd, nxt_alu, nxt_mem, nxt_wbt, nxt_wb, nxt_from_alu} = '0;
            {nxt_a, nxt_b, nxt_sd} = '0;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {exp_rd, exp_alu_op, exp_mem_op, exp_wb_type} <= '0;
            {exp_wb_en, exp_wb_from_alu, exp_illegal} <= '0;
            {exp_alu_a, exp_alu_b, exp_store_data} <= '0;
            hist <= '{REG_ZERO, REG_ZERO, REG_ZERO};
        end else begin
            {exp_rd, exp_alu_op, exp_mem_op, exp_wb_type} <= {nxt_rd, nxt_alu, nxt_mem, nxt_wbt};
            {exp_wb_en, exp_wb_from_alu, exp_illegal} <= {nxt_wb, nxt_from_alu, nxt_ill};
            {exp_alu_a, exp_alu_b, exp_store_data} <= {nxt_a, nxt_b, nxt_sd};
            hist <= '{nxt_rd, hist[0], hist[1]};  // nxt_rd is x0 for stores and illegal slots
        end
    end

    task automatic log_mismatch(input bit is_addr, input string name,
                                input logic [31:0] exp, input logic [31:0] act);
        if (is_addr) addr_errs++;
        else val_errs++;
        $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) rs1_addr == nxt_rs1)
        else log_mismatch(1, "rs1_addr", $sampled(nxt_rs1), $sampled(rs1_addr));
    assert property (@(posedge clk) disable iff (!rst_n) rs2_addr == nxt_rs2)
        else log_mismatch(1, "rs2_addr", $sampled(nxt_rs2), $sampled(rs2_addr));
    assert property (@(posedge clk) disable iff (!rst_n) ex_rd == exp_rd)
        else log_mismatch(0, "ex_rd", $sampled(exp_rd), $sampled(ex_rd));
    assert property (@(posedge clk) disable iff (!rst_n) ex_alu_op == exp_alu_op)
        else log_mismatch(0, "ex_alu_op", $sampled(exp_alu_op), $sampled(ex_alu_op));
    assert property (@(posedge clk) disable iff (!rst_n) ex_mem_op == exp_mem_op)
        else log_mismatch(0, "ex_mem_op", $sampled(exp_mem_op), $sampled(ex_mem_op));
    assert property (@(posedge clk) disable iff (!rst_n) ex_wb_type == exp_wb_type)
        else log_mismatch(0, "ex_wb_type", $sampled(exp_wb_type), $sampled(ex_wb_type));
    assert property (@(posedge clk) disable iff (!rst_n) ex_wb_en == exp_wb_en)
        else log_mismatch(0, "ex_wb_en", $sampled(exp_wb_en), $sampled(ex_wb_en));
    assert property (@(posedge clk) disable iff (!rst_n) ex_wb_from_alu == exp_wb_from_alu)
        else log_mismatch(0, "ex_wb_from_alu", $sampled(exp_wb_from_alu),
                          $sampled(ex_wb_from_alu));
    assert property (@(posedge clk) disable iff (!rst_n) ex_illegal == exp_illegal)
        else log_mismatch(0, "ex_illegal", $sampled(exp_illegal), $sampled(ex_illegal));
    assert property (@(posedge clk) disable iff (!rst_n) ex_alu_a == exp_alu_a)
        else log_mismatch(0, "ex_alu_a", $sampled(exp_alu_a), $sampled(ex_alu_a));
    assert property (@(posedge clk) disable iff (!rst_n) ex_alu_b == exp_alu_b)
        else log_mismatch(0, "ex_alu_b", $sampled(exp_alu_b), $sampled(ex_alu_b));
    assert property (@(posedge clk) disable iff (!rst_n) ex_store_data == exp_store_data)
        else log_mismatch(0, "ex_store_data", $sampled(exp_store_data), $sampled(ex_store_data));

    // New slot each edge with fresh stage results and one changed register
    task automatic apply(input inst_t ins);
        logic [31:0] r;
        @(posedge clk);
        r = $random(seed);
        instr      <= ins;
        ex_result  <= $random(seed);
        mem_result <= $random(seed);
        wb_result  <= $random(seed);
        if (r[4:0] != 5'd0)
            regs[r[4:0]] <= $random(seed);  // x0 keeps reading zero
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        seed       = 32'ha900;
        rst_n      = 1'b0;
        instr      = '0;
        ex_result  = '0;
        mem_result = '0;
        wb_result  = '0;
        for (int i = 0; i < 32; i++)
            regs[i] = (i == 0) ? '0 : $random(seed);
        repeat (2) dir_q.push_back('0);  // Leading bubbles
        for (int f = 0; f < 8; f++) begin  // Every funct3 of each format including undefined ones
            dir_q.push_back(i_type(12'h013, 5'd1, 3'(f), 5'd2, OPC_OP_IMM));
            dir_q.push_back(r_type(7'h00, 5'd3, 5'd4, 3'(f), 5'd5));
            dir_q.push_back(i_type(12'hF9C, 5'd6, 3'(f), 5'd7, OPC_LOAD));
            dir_q.push_back(s_type(12'h83F, 5'd8, 5'd9, 3'(f)));
        end
        dir_q.push_back(i_type(12'h405, 5'd1, F3_SRL_SRA, 5'd2, OPC_OP_IMM));  // SRAI
        dir_q.push_back(i_type(12'h800, 5'd1, F3_ADD_SUB, 5'd2, OPC_OP_IMM));  // -2048
        dir_q.push_back(r_type(7'h20, 5'd3, 5'd4, F3_ADD_SUB, 5'd5));          // SUB
        dir_q.push_back(r_type(7'h20, 5'd3, 5'd4, F3_SRL_SRA, 5'd5));          // SRA
        foreach (dropped[i])
            dir_q.push_back(i_type(12'h004, 5'd1, 3'd0, 5'd10, dropped[i]));
        dir_q.push_back(32'h0000_0500);  // Opcode zero with rd x10
        dir_q.push_back(r_type(7'h00, 5'd10, 5'd10, F3_ADD_SUB, 5'd11));  // x10 never forwarded
        for (int i = 5; i < 8; i++)
            dir_q.push_back(i_type(12'(i), 5'd0, F3_ADD_SUB, 5'(i), OPC_OP_IMM));
        dir_q.push_back(r_type(7'h00, 5'd6, 5'd5, F3_ADD_SUB, 5'd8));  // WB and MEM paths
        dir_q.push_back(r_type(7'h00, 5'd7, 5'd8, F3_ADD_SUB, 5'd9));  // EX and MEM paths
        repeat (3) dir_q.push_back(i_type(12'h001, 5'd0, F3_ADD_SUB, 5'd5, OPC_OP_IMM));
        dir_q.push_back(r_type(7'h00, 5'd5, 5'd5, F3_ADD_SUB, 5'd1));  // Youngest x5 wins
        dir_q.push_back(i_type(12'h005, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM));
        dir_q.push_back(r_type(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd2));
        dir_q.push_back(s_type(12'h003, 5'd3, 5'd4, F3_SW));  // Offset bits look like rd x3
        dir_q.push_back(r_type(7'h00, 5'd3, 5'd3, F3_ADD_SUB, 5'd11));
        dir_q.push_back(i_type(12'h007, 5'd0, F3_ADD_SUB, 5'd12, OPC_OP_IMM));
        dir_q.push_back(s_type(12'h004, 5'd12, 5'd12, F3_SW));  // Base and data forwarded
        dir_q.push_back(i_type(12'h000, 5'd1, F3_LW, 5'd15, OPC_LOAD));
        dir_q.push_back(r_type(7'h00, 5'd15, 5'd15, F3_ADD_SUB, 5'd16));
        dir_q.push_back(i_type(12'h000, 5'd0, 3'd0, 5'd13, 7'h6F));  // JAL x13
        dir_q.push_back(r_type(7'h00, 5'd13, 5'd13, F3_ADD_SUB, 5'd14));
        cycle_limit = 2 * (dir_q.size() + RAND_CYCLES + TAIL_CYCLES) + RST_CYCLES;

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        foreach (dir_q[i])
            apply(dir_q[i]);
        repeat (RAND_CYCLES) apply(random_instr());
        repeat (TAIL_CYCLES) apply('0);
        @(negedge clk);
        $display("Errors: %0d on ex outputs, %0d on read addresses", val_errs, addr_errs);
        if (val_errs + addr_errs == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
